// ==== common/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define CACHE_SETS 4
`define CACHE_WAYS 4
`define LINE_BYTES 16

// Physical address layout
// Tag is bits 14:7, index 6:5, offset 3:0, bit 4 unused
`define PADDR_W 15
`define TAG_W 8

// Access queue size and credit pools
`define AQ_DEPTH 4
`define AQ_CREDITS 1
`define OUT_CREDITS 2

`endif

// ==== common/dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

  // Access size in bytes
  typedef enum logic [1:0] {
    SIZE_1 = 2'd0,
    SIZE_2 = 2'd1,
    SIZE_4 = 2'd2,
    SIZE_8 = 2'd3
  } size_e;

  // One cache line, by byte or by 64-bit half
  typedef union packed {
    logic [`LINE_BYTES-1:0][7:0] bytes;
    logic [1:0][63:0]            halves;
  } line_u;

  typedef struct packed {
    logic                     is_write;
    logic [`PADDR_W-1:0]      paddr;
    logic [`LINE_BYTES*8-1:0] data;
    logic [`LINE_BYTES-1:0]   mask;
    size_e                    size;
    logic [6:0]               tag_id;
  } req_t;

  // Bank to aligner
  typedef struct packed {
    line_u      line;
    logic [3:0] offset;
    size_e      size;
    logic [6:0] tag_id;
  } hit_t;

  typedef struct packed {
    logic [63:0] value;
    logic [6:0]  tag_id;
  } result_t;

  typedef struct packed {
    logic [`PADDR_W-1:0] paddr;
  } fill_req_t;

  typedef struct packed {
    logic [`LINE_BYTES*8-1:0] line;
  } fill_rsp_t;

  // Write-through record for every store
  typedef struct packed {
    logic [`PADDR_W-1:0]      paddr;
    logic [`LINE_BYTES*8-1:0] data;
    logic [`LINE_BYTES-1:0]   mask;
  } wt_t;

endpackage

// ==== access_queue/access_queue.sv ====
`timescale 1ns/10ps
`include "dcache_config.svh"

module access_queue #(
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  dcache_pkg::req_t in_req,
  output logic             in_ready,
  output logic             aq_valid,
  output dcache_pkg::req_t aq_req,
  input  logic             bank_credit
);

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(`AQ_CREDITS + 1);

  dcache_pkg::req_t  entries [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;
  logic              push;

  assign in_ready = (count != CNT_W'(DEPTH));
  assign push     = in_valid && in_ready;

  // Head goes out whenever the bank has room for it
  assign aq_valid = (count != '0) && (credits != '0);
  assign aq_req   = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRED_W'(`AQ_CREDITS);
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (aq_valid) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count + CNT_W'(push) - CNT_W'(aq_valid);
      // One credit per issue, returned when the bank is done
      credits <= credits + CRED_W'(bank_credit) - CRED_W'(aq_valid);
    end
  end

endmodule

// ==== cache_bank/tag_array.sv ====
`timescale 1ns/10ps
`include "dcache_config.svh"

module tag_array (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [$clog2(`CACHE_SETS)-1:0]   index,
  input  logic [`TAG_W-1:0]                tag,
  input  logic                             lookup,
  output logic                             hit,
  output logic [$clog2(`CACHE_WAYS)-1:0]   hit_way,
  input  logic                             replace,
  output logic [$clog2(`CACHE_WAYS)-1:0]   victim_way
);

  localparam int WAYS  = `CACHE_WAYS;
  localparam int WAY_W = $clog2(`CACHE_WAYS);

  logic [`TAG_W-1:0]            tags  [`CACHE_SETS][WAYS];
  logic [WAYS-1:0]              valid [`CACHE_SETS];
  // Entry 0 is least recent, last entry most recent
  logic [WAYS-1:0][WAY_W-1:0]   order [`CACHE_SETS];
  logic [WAYS-1:0][WAY_W-1:0]   new_order;
  logic [WAY_W-1:0]             used_way;
  logic                         touch;

  always_comb begin
    hit        = 1'b0;
    hit_way    = '0;
    victim_way = order[index][0];
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (valid[index][w] && tags[index][w] == tag) begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
      if (!valid[index][w]) victim_way = WAY_W'(w);
    end
  end

  assign used_way = replace ? victim_way : hit_way;
  assign touch    = replace || (lookup && hit);

  // Remaining ways slide down, used way moves to the top
  always_comb begin
    int j;
    j         = 0;
    new_order = order[index];
    for (int i = 0; i < WAYS; i++) begin
      if (order[index][i] != used_way) begin
        new_order[j] = order[index][i];
        j++;
      end
    end
    new_order[WAYS-1] = used_way;
  end

  always_ff @(posedge clk) begin
    if (replace) tags[index][victim_way] <= tag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid[s] <= '0;
        for (int w = 0; w < WAYS; w++) order[s][w] <= WAY_W'(w);
      end
    end else begin
      if (replace) valid[index][victim_way] <= 1'b1;
      if (touch) order[index] <= new_order;
    end
  end

endmodule

// ==== cache_bank/cache_bank.sv ====
`timescale 1ns/10ps
`include "dcache_config.svh"

module cache_bank (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  aq_valid,
  input  dcache_pkg::req_t      aq_req,
  output logic                  bank_credit,
  output logic                  hit_valid,
  output dcache_pkg::hit_t      hit,
  input  logic                  align_credit,
  output logic                  fill_req_valid,
  output dcache_pkg::fill_req_t fill_req,
  input  logic                  fill_rsp_valid,
  input  dcache_pkg::fill_rsp_t fill_rsp,
  output logic                  wt_valid,
  output dcache_pkg::wt_t       wt
);

  localparam int IDX_W  = $clog2(`CACHE_SETS);
  localparam int WAY_W  = $clog2(`CACHE_WAYS);
  localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_WAIT_FILL, ST_WAIT_CREDIT} state_e;

  state_e            state;
  dcache_pkg::req_t  req_q;
  logic [CRED_W-1:0] credits;
  dcache_pkg::line_u lines [`CACHE_SETS][`CACHE_WAYS];
  logic [IDX_W-1:0]  index;
  logic [`TAG_W-1:0] tag;
  logic              tag_hit;
  logic [WAY_W-1:0]  hit_way;
  logic [WAY_W-1:0]  victim_way;
  logic              lookup;
  logic              replace;

  assign index   = req_q.paddr[6:5];
  assign tag     = req_q.paddr[`PADDR_W-1 -: `TAG_W];
  assign lookup  = (state == ST_LOOKUP);
  assign replace = (state == ST_WAIT_FILL) && fill_rsp_valid;

  tag_array i_tags (
    .clk       (clk),
    .reset     (reset),
    .index     (index),
    .tag       (tag),
    .lookup    (lookup),
    .hit       (tag_hit),
    .hit_way   (hit_way),
    .replace   (replace),
    .victim_way(victim_way)
  );

  // Load hit leaves only with an aligner credit in hand
  assign hit_valid = (state == ST_LOOKUP || state == ST_WAIT_CREDIT) && !req_q.is_write &&
                     tag_hit && (credits != '0);
  assign wt_valid       = lookup && req_q.is_write;
  assign fill_req_valid = lookup && !req_q.is_write && !tag_hit;
  assign bank_credit    = hit_valid || wt_valid;

  assign hit = '{line: lines[index][hit_way], offset: req_q.paddr[3:0],
                 size: req_q.size, tag_id: req_q.tag_id};
  assign fill_req = '{paddr: {req_q.paddr[`PADDR_W-1:4], 4'b0000}};
  assign wt = '{paddr: req_q.paddr, data: req_q.data, mask: req_q.mask};

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && aq_valid) begin
      req_q <= aq_req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      credits <= CRED_W'(`OUT_CREDITS);
    end else begin
      credits <= credits + CRED_W'(align_credit) - CRED_W'(hit_valid);
      case (state)
        ST_IDLE: if (aq_valid) state <= ST_LOOKUP;
        ST_LOOKUP: begin
          if (req_q.is_write || hit_valid) state <= ST_IDLE;
          else if (tag_hit) state <= ST_WAIT_CREDIT;
          else state <= ST_WAIT_FILL;
        end
        // Filled line is presented from the next cycle on
        ST_WAIT_FILL: if (fill_rsp_valid) state <= ST_WAIT_CREDIT;
        ST_WAIT_CREDIT: if (hit_valid) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Fill install, or byte merge of a store that hits
  always_ff @(posedge clk) begin
    if (replace) begin
      lines[index][victim_way] <= fill_rsp.line;
    end else if (wt_valid && tag_hit) begin
      for (int b = 0; b < `LINE_BYTES; b++) begin
        if (req_q.mask[b]) begin
          lines[index][hit_way].bytes[b] <= req_q.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== src/output_align.sv ====
`timescale 1ns/10ps
`include "dcache_config.svh"

module output_align (
  input  logic                clk,
  input  logic                reset,
  input  logic                hit_valid,
  input  dcache_pkg::hit_t    hit,
  output logic                align_credit,
  output logic                out_valid,
  output dcache_pkg::result_t out_res,
  input  logic                out_credit
);

  // One slot per credit the bank may spend
  localparam int DEPTH = `OUT_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  dcache_pkg::result_t res_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic [CNT_W-1:0]    credits;
  logic [63:0]         half;
  logic [63:0]         shifted;
  logic [63:0]         value;

  // Half by offset bit 3, then byte shift and zero-extend
  always_comb begin
    half    = hit.line.halves[hit.offset[3]];
    shifted = half >> {hit.offset[2:0], 3'b000};
    case (hit.size)
      dcache_pkg::SIZE_1: value = {56'd0, shifted[7:0]};
      dcache_pkg::SIZE_2: value = {48'd0, shifted[15:0]};
      dcache_pkg::SIZE_4: value = {32'd0, shifted[31:0]};
      default:            value = shifted;
    endcase
  end

  assign out_valid    = (count != '0) && (credits != '0);
  assign out_res      = res_q[rd_ptr];
  assign align_credit = out_valid;

  always_ff @(posedge clk) begin
    if (hit_valid) res_q[wr_ptr] <= '{value: value, tag_id: hit.tag_id};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CNT_W'(DEPTH);
    end else begin
      if (hit_valid) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (out_valid) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count   <= count + CNT_W'(hit_valid) - CNT_W'(out_valid);
      credits <= credits + CNT_W'(out_credit) - CNT_W'(out_valid);
    end
  end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  dcache_pkg::req_t      in_req,
  output logic                  in_ready,
  output logic                  out_valid,
  output dcache_pkg::result_t   out_res,
  input  logic                  out_credit,
  output logic                  fill_req_valid,
  output dcache_pkg::fill_req_t fill_req,
  input  logic                  fill_rsp_valid,
  input  dcache_pkg::fill_rsp_t fill_rsp,
  output logic                  wt_valid,
  output dcache_pkg::wt_t       wt
);

  logic             aq_valid;
  dcache_pkg::req_t aq_req;
  logic             bank_credit;
  logic             hit_valid;
  dcache_pkg::hit_t hit;
  logic             align_credit;

  access_queue #(.DEPTH(`AQ_DEPTH)) i_queue (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_req(in_req), .in_ready(in_ready),
    .aq_valid(aq_valid), .aq_req(aq_req), .bank_credit(bank_credit)
  );

  cache_bank i_bank (
    .clk(clk), .reset(reset),
    .aq_valid(aq_valid), .aq_req(aq_req), .bank_credit(bank_credit),
    .hit_valid(hit_valid), .hit(hit), .align_credit(align_credit),
    .fill_req_valid(fill_req_valid), .fill_req(fill_req),
    .fill_rsp_valid(fill_rsp_valid), .fill_rsp(fill_rsp),
    .wt_valid(wt_valid), .wt(wt)
  );

  output_align i_align (
    .clk(clk), .reset(reset),
    .hit_valid(hit_valid), .hit(hit), .align_credit(align_credit),
    .out_valid(out_valid), .out_res(out_res), .out_credit(out_credit)
  );

endmodule

// ==== tests/dcache_tb_table.svh ====
// Columns: is_write, paddr, store word (repeated over the line), byte mask, size code,
// expected number of fill requests for the row
localparam int NUM_ROWS = 18;

row_t rows [NUM_ROWS] = '{
  '{1'b0, 15'h0080, 32'h0000_0000, 16'h0000, 2'd3, 1'b1},
  '{1'b0, 15'h0080, 32'h0000_0000, 16'h0000, 2'd3, 1'b0},
  '{1'b0, 15'h0084, 32'h0000_0000, 16'h0000, 2'd2, 1'b0},
  '{1'b0, 15'h008a, 32'h0000_0000, 16'h0000, 2'd1, 1'b0},
  '{1'b0, 15'h008f, 32'h0000_0000, 16'h0000, 2'd0, 1'b0},
  '{1'b1, 15'h0088, 32'ha5c3_5a3c, 16'h0f00, 2'd3, 1'b0},
  '{1'b0, 15'h0088, 32'h0000_0000, 16'h0000, 2'd3, 1'b0},
  '{1'b1, 15'h0400, 32'h1234_5678, 16'h00ff, 2'd3, 1'b0},
  '{1'b0, 15'h0400, 32'h0000_0000, 16'h0000, 2'd3, 1'b1},
  '{1'b0, 15'h10a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b1},
  '{1'b0, 15'h11a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b1},
  '{1'b0, 15'h12a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b1},
  '{1'b0, 15'h13a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b1},
  '{1'b0, 15'h14a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b1},
  '{1'b0, 15'h10a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b1},
  '{1'b0, 15'h14a0, 32'h0000_0000, 16'h0000, 2'd2, 1'b0},
  '{1'b1, 15'h12a4, 32'hdead_beef, 16'h00f0, 2'd3, 1'b0},
  '{1'b0, 15'h12a4, 32'h0000_0000, 16'h0000, 2'd2, 1'b0}
};

// ==== tests/dcache_tb.sv ====
`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_tb;

  typedef struct packed {
    logic        is_write;
    logic [14:0] addr;
    logic [31:0] word;
    logic [15:0] mask;
    logic [1:0]  size;
    logic        exp_fill;
  } row_t;

  `include "dcache_tb_table.svh"

  localparam int TIMEOUT = NUM_ROWS * 40;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic in_valid = 1'b0;
  dcache_pkg::req_t in_req = '0;
  logic in_ready;
  logic out_valid;
  dcache_pkg::result_t out_res;
  logic out_credit = 1'b0;
  logic fill_req_valid;
  dcache_pkg::fill_req_t fill_req;
  logic fill_rsp_valid = 1'b0;
  dcache_pkg::fill_rsp_t fill_rsp = '0;
  logic wt_valid;
  dcache_pkg::wt_t wt;

  logic [127:0] mem [2048];
  logic [127:0] ref_mem [2048];
  dcache_pkg::result_t got_q [$];
  dcache_pkg::result_t exp_q [$];
  dcache_pkg::wt_t wt_q [$];
  int errors = 0;
  int failed_tests = 0;
  int cycles = 0;
  int fill_count = 0;
  int fill_wait = 0;
  int owed = 0;
  logic hold = 1'b0;
  logic [10:0] fill_line;
  logic [14:0] fill_addr;

  dcache_top i_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the DUT stopped responding after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  // Memory side and result consumer, sampled on the rising edge
  always @(posedge clk) begin
    if (fill_req_valid) begin
      fill_count++;
      fill_addr = fill_req.paddr;
      fill_line = fill_req.paddr[14:4];
      fill_wait = 1 + ($urandom % 8);
    end
    if (wt_valid) begin
      wt_q.push_back(wt);
      for (int b = 0; b < 16; b++)
        if (wt.mask[b]) mem[wt.paddr[14:4]][b*8 +: 8] = wt.data[b*8 +: 8];
    end
    if (out_valid) begin
      got_q.push_back(out_res);
      owed++;
    end
  end

  always @(negedge clk) begin
    fill_rsp_valid = 1'b0;
    if (fill_wait > 0) begin
      fill_wait--;
      if (fill_wait == 0) begin
        fill_rsp_valid = 1'b1;
        fill_rsp.line = mem[fill_line];
      end
    end
    out_credit = 1'b0;
    if (!hold && owed > 0) begin
      out_credit = 1'b1;
      owed--;
    end
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Expected load value built byte by byte from the reference memory
  function automatic logic [63:0] predict(input logic [14:0] addr, input logic [1:0] size);
    logic [127:0] line;
    logic [63:0] v;
    int n;
    line = ref_mem[addr[14:4]];
    v = '0;
    n = 1 << size;
    for (int i = 0; i < n; i++) v[i*8 +: 8] = line[(addr[3:0] + i)*8 +: 8];
    return v;
  endfunction

  function automatic dcache_pkg::req_t make_req(input row_t r, input int id);
    dcache_pkg::req_t q;
    q.is_write = r.is_write;
    q.paddr = r.addr;
    q.data = {4{r.word}};
    q.mask = r.mask;
    q.size = dcache_pkg::size_e'(r.size);
    q.tag_id = 7'(id);
    return q;
  endfunction

  task automatic send_req(input dcache_pkg::req_t q);
    @(negedge clk);
    in_valid = 1'b1;
    in_req = q;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic run_row(input int id);
    dcache_pkg::req_t q;
    dcache_pkg::result_t res;
    dcache_pkg::wt_t w;
    int fills_before;
    int errors_before;
    errors_before = errors;
    fills_before = fill_count;
    q = make_req(rows[id], id);
    if (q.is_write) begin
      for (int b = 0; b < 16; b++)
        if (q.mask[b]) ref_mem[q.paddr[14:4]][b*8 +: 8] = q.data[b*8 +: 8];
      send_req(q);
      while (wt_q.size() == 0) @(posedge clk);
      w = wt_q.pop_front();
      check("wt.paddr", w.paddr, q.paddr);
      check("wt.data", w.data, q.data);
      check("wt.mask", w.mask, q.mask);
    end else begin
      send_req(q);
      while (got_q.size() == 0) @(posedge clk);
      res = got_q.pop_front();
      check("out_res.value", res.value, predict(q.paddr, q.size));
      check("out_res.tag_id", res.tag_id, q.tag_id);
      if (rows[id].exp_fill) check("fill_req.paddr", fill_addr, {q.paddr[14:4], 4'h0});
    end
    check("fill count", fill_count - fills_before, rows[id].exp_fill);
    if (errors != errors_before) failed_tests++;
    $display("test %0d %s 0x%h: %s", id, q.is_write ? "store" : "load", q.paddr,
             (errors == errors_before) ? "ok" : "failed");
  endtask

  // Loads to a cached line while the consumer withholds credits
  task automatic run_backpressure();
    row_t r;
    dcache_pkg::result_t res;
    dcache_pkg::result_t exp_res;
    int sent;
    int idle;
    int got_before;
    int errors_before;
    errors_before = errors;
    sent = 0;
    idle = 0;
    // Consumer hands back every earlier credit first
    while (owed > 0) @(posedge clk);
    hold = 1'b1;
    got_before = got_q.size();
    while (idle < 20) begin
      r = '{1'b0, 15'h0080 + 15'(sent % 8), 32'h0, 16'h0, 2'd0, 1'b0};
      @(negedge clk);
      in_valid = (sent < 12);
      in_req = make_req(r, 64 + sent);
      @(posedge clk);
      if (in_valid && in_ready) begin
        exp_res.value = predict(r.addr, r.size);
        exp_res.tag_id = 7'(64 + sent);
        exp_q.push_back(exp_res);
        sent++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    check("results while held", got_q.size() - got_before, `OUT_CREDITS);
    check("in_ready", in_ready, 1'b0);
    hold = 1'b0;
    while (got_q.size() < sent) @(posedge clk);
    while (exp_q.size() > 0) begin
      res = got_q.pop_front();
      check("out_res", res, exp_q.pop_front());
    end
    if (errors != errors_before) failed_tests++;
    $display("test %0d backpressure, %0d loads: %s", NUM_ROWS, sent,
             (errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(32'h1de4_4421));
    for (int i = 0; i < 2048; i++) begin
      mem[i] = {$urandom, $urandom, $urandom, $urandom};
      ref_mem[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    run_backpressure();
    $display("%0d tests, %0d failed, %0d errors", NUM_ROWS + 1, failed_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== dcache.f ====
+incdir+common
+incdir+tests
common/dcache_pkg.sv
access_queue/access_queue.sv
cache_bank/tag_array.sv
cache_bank/cache_bank.sv
src/output_align.sv
src/dcache_top.sv
tests/dcache_tb.sv
